// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fpu_issue_tb
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FILELIST ?= compile.f
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
fpu_pkg.sv
opd_station.sv
itof_convert.sv
fsgn_unit.sv
fpr_cdb_arbiter.sv
fpu_issue_top.sv
fpu_issue_asserts.sv
fpu_issue_tb.sv

// ==== fpr_cdb_arbiter.sv ====
`timescale 1ns/1ps

module fpr_cdb_arbiter (
	input logic clk,
	input logic reset,
	input logic req_itof,
	input logic [fpu_pkg::ROB_WIDTH-1:0] tag_itof,
	input fpu_pkg::fp_word_u data_itof,
	input logic req_fsgn,
	input logic [fpu_pkg::ROB_WIDTH-1:0] tag_fsgn,
	input fpu_pkg::fp_word_u data_fsgn,
	input logic fpr_cdb_ready,
	output logic gnt_itof,
	output logic gnt_fsgn,
	output logic fpr_cdb_valid,
	output logic [fpu_pkg::ROB_WIDTH-1:0] fpr_cdb_tag,
	output fpu_pkg::fp_word_u fpr_cdb_data
);
	// Set when the sign unit won the last delivery
	logic last_fsgn;
	logic pick_fsgn;

	// On a tie the unit that lost last time goes first
	assign pick_fsgn = req_fsgn && (!req_itof || !last_fsgn);

	assign fpr_cdb_valid = req_itof || req_fsgn;
	assign fpr_cdb_tag = pick_fsgn ? tag_fsgn : tag_itof;
	assign fpr_cdb_data = pick_fsgn ? data_fsgn : data_itof;

	assign gnt_fsgn = pick_fsgn && fpr_cdb_ready;
	assign gnt_itof = req_itof && !pick_fsgn && fpr_cdb_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			last_fsgn <= 1'b0;
		end else if (fpr_cdb_valid && fpr_cdb_ready) begin
			last_fsgn <= pick_fsgn;
		end
	end

endmodule

// ==== fpu_issue_asserts.sv ====
`timescale 1ns/1ps

module fpu_issue_asserts (
	input logic clk,
	input logic reset,
	input logic fpr_cdb_valid,
	input logic fpr_cdb_ready,
	input logic req_itof,
	input logic gnt_itof,
	input logic [fpu_pkg::ROB_WIDTH-1:0] tag_itof,
	input fpu_pkg::fp_word_u data_itof,
	input logic req_fsgn,
	input logic gnt_fsgn,
	input logic [fpu_pkg::ROB_WIDTH-1:0] tag_fsgn,
	input fpu_pkg::fp_word_u data_fsgn,
	input logic itof_issue_ready,
	input logic fsgn_issue_ready,
	input logic [fpu_pkg::N_ENTRY-1:0] itof_occ,
	input logic [fpu_pkg::N_ENTRY-1:0] fsgn_occ
);
	// Out of reset the bus is idle and both stations take issues
	reset_idle: assert property (@(posedge clk)
		$fell(reset) |-> !fpr_cdb_valid && itof_issue_ready && fsgn_issue_ready)
		else $error("FPR CDB busy or station not ready right after reset");

	cdb_held: assert property (@(posedge clk) disable iff (reset)
		fpr_cdb_valid && !fpr_cdb_ready |=> fpr_cdb_valid)
		else $error("FPR CDB valid dropped without a delivery");

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result slots hold until granted
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	itof_slot_hold: assert property (@(posedge clk) disable iff (reset)
		req_itof && !gnt_itof |=> req_itof && $stable(tag_itof) && $stable(data_itof))
		else $error("Conversion result slot changed while waiting for grant");

	fsgn_slot_hold: assert property (@(posedge clk) disable iff (reset)
		req_fsgn && !gnt_fsgn |=> req_fsgn && $stable(tag_fsgn) && $stable(data_fsgn))
		else $error("Sign unit result slot changed while waiting for grant");

	// A station that is not ready takes nothing in
	itof_no_issue: assert property (@(posedge clk) disable iff (reset)
		!itof_issue_ready |=> $stable(itof_occ))
		else $error("Conversion station changed while issue_ready was low");

	fsgn_no_issue: assert property (@(posedge clk) disable iff (reset)
		!fsgn_issue_ready |=> $stable(fsgn_occ))
		else $error("Sign station changed while issue_ready was low");

endmodule

// ==== fpu_issue_tb.sv ====
`timescale 1ns/1ps

module fpu_issue_tb;

	typedef logic [fpu_pkg::ROB_WIDTH-1:0] tag_t;
	localparam int N_TAGS = 2 ** fpu_pkg::ROB_WIDTH;
	localparam int N_TESTS = 6;

	logic clk = 1'b0;
	logic reset;
	logic itof_issue_valid;
	logic fsgn_issue_valid;
	logic [fpu_pkg::OP_WIDTH-1:0] issue_op;
	tag_t issue_tag;
	logic opd_valid;
	tag_t opd_tag;
	logic [fpu_pkg::XLEN-1:0] opd_data;
	logic gpr_cdb_valid;
	tag_t gpr_cdb_tag;
	logic [fpu_pkg::XLEN-1:0] gpr_cdb_data;
	logic fpr_cdb_ready;
	logic itof_issue_ready;
	logic fsgn_issue_ready;
	logic fpr_cdb_valid;
	tag_t fpr_cdb_tag;
	fpu_pkg::fp_word_u fpr_cdb_data;

	// Scoreboard indexed by tag
	fpu_pkg::fp_word_u sb_word [N_TAGS];
	int sb_count [N_TAGS];
	fpu_pkg::fp_word_u exp_word [N_TAGS];
	logic exp_used [N_TAGS];
	tag_t order_q [$];
	int n_delivered = 0;
	int errors = 0;
	int checks = 0;

	always #5 clk = ~clk;

	fpu_issue_top u_fpu_issue_top (
		.clk(clk),
		.reset(reset),
		.itof_issue_valid(itof_issue_valid),
		.fsgn_issue_valid(fsgn_issue_valid),
		.issue_op(issue_op),
		.issue_tag(issue_tag),
		.opd_valid(opd_valid),
		.opd_tag(opd_tag),
		.opd_data(opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.fpr_cdb_ready(fpr_cdb_ready),
		.itof_issue_ready(itof_issue_ready),
		.fsgn_issue_ready(fsgn_issue_ready),
		.fpr_cdb_valid(fpr_cdb_valid),
		.fpr_cdb_tag(fpr_cdb_tag),
		.fpr_cdb_data(fpr_cdb_data)
	);

	bind fpu_issue_top fpu_issue_asserts u_fpu_issue_asserts (
		.clk(clk),
		.reset(reset),
		.fpr_cdb_valid(fpr_cdb_valid),
		.fpr_cdb_ready(fpr_cdb_ready),
		.req_itof(req_itof),
		.gnt_itof(gnt_itof),
		.tag_itof(tag_itof),
		.data_itof(data_itof),
		.req_fsgn(req_fsgn),
		.gnt_fsgn(gnt_fsgn),
		.tag_fsgn(tag_fsgn),
		.data_fsgn(data_fsgn),
		.itof_issue_ready(itof_issue_ready),
		.fsgn_issue_ready(fsgn_issue_ready),
		.itof_occ(u_itof_station.e_valid),
		.fsgn_occ(u_fsgn_station.e_valid)
	);

	// Deliveries sampled mid-cycle
	always @(negedge clk) begin
		if (!reset && fpr_cdb_valid && fpr_cdb_ready) begin
			sb_count[fpr_cdb_tag] = sb_count[fpr_cdb_tag] + 1;
			sb_word[fpr_cdb_tag] = fpr_cdb_data;
			order_q.push_back(fpr_cdb_tag);
			n_delivered = n_delivered + 1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic fpu_pkg::fp_word_u ref_itof(input logic [31:0] v, input logic is_signed);
		fpu_pkg::fp_word_u w;
		logic neg;
		logic [31:0] mag32;
		logic [63:0] mag;
		logic [63:0] kept;
		logic [63:0] rem;
		logic [63:0] half;
		int msb;
		int sh;
		neg = is_signed && v[31];
		mag32 = neg ? ~v + 32'd1 : v;
		mag = 64'(mag32);
		w.raw = '0;
		if (mag == 64'd0) begin
			return w;
		end
		msb = 0;
		for (int i = 0; i < 64; i++) begin
			if (mag[i]) begin
				msb = i;
			end
		end
		sh = msb - 23;
		if (sh > 0) begin
			kept = mag >> sh;
			rem = mag - (kept << sh);
			half = 64'd1 << (sh - 1);
			// Ties go to the even value
			if (rem > half || (rem == half && kept[0])) begin
				kept = kept + 64'd1;
			end
			if (kept[24]) begin
				kept = kept >> 1;
				msb = msb + 1;
			end
		end else begin
			kept = mag << (-sh);
		end
		w.fields.sign = neg;
		w.fields.exp = 8'(msb + fpu_pkg::EXP_BIAS);
		w.fields.frac = kept[22:0];
		return w;
	endfunction

	function automatic fpu_pkg::fp_word_u ref_fsgn(input logic [1:0] op, input logic [31:0] v);
		fpu_pkg::fp_word_u w;
		w.raw = v;
		if (op == fpu_pkg::OP_FSGN_NEG) begin
			w.raw = v ^ 32'h8000_0000;
		end else if (op == fpu_pkg::OP_FSGN_ABS) begin
			w.raw = v & 32'h7fff_ffff;
		end
		return w;
	endfunction

	function automatic fpu_pkg::fp_word_u expect_of(input logic is_itof, input logic [1:0] op,
		input logic [31:0] v);
		if (is_itof) begin
			return ref_itof(v, op == fpu_pkg::OP_ITOF_SIGNED);
		end
		return ref_fsgn(op, v);
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Compare and bookkeeping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_word(input string name, input fpu_pkg::fp_word_u exp_w,
		input fpu_pkg::fp_word_u act_w);
		checks++;
		if (act_w.raw !== exp_w.raw) begin
			$display("[ERROR] %s expected %08h actual %08h", name, exp_w.raw, act_w.raw);
			errors++;
		end
	endtask

	task automatic check_tag(input string name, input tag_t exp_t, input tag_t act_t);
		checks++;
		if (act_t !== exp_t) begin
			$display("[ERROR] %s expected %0d actual %0d", name, exp_t, act_t);
			errors++;
		end
	endtask

	task automatic clear_scoreboard();
		for (int t = 0; t < N_TAGS; t++) begin
			sb_count[t] = 0;
			exp_used[t] = 1'b0;
		end
		n_delivered = 0;
		order_q.delete();
	endtask

	task automatic verify_scoreboard(input string name);
		for (int t = 0; t < N_TAGS; t++) begin
			check_tag($sformatf("%s count of tag %0d", name, t),
				exp_used[t] ? tag_t'(1) : tag_t'(0), tag_t'(sb_count[t]));
			if (exp_used[t] && sb_count[t] > 0) begin
				check_word($sformatf("%s tag %0d", name, t), exp_word[t], sb_word[t]);
			end
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s: %s, %0d errors", name, errors == errors_before ? "ok" : "failed",
			errors - errors_before);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Drivers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic try_issue(input logic is_itof, input logic [1:0] op, input tag_t tag,
		input logic [31:0] data, input logic rdy, input tag_t otag, output logic ok);
		@(posedge clk);
		#1;
		itof_issue_valid = is_itof;
		fsgn_issue_valid = !is_itof;
		issue_op = op;
		issue_tag = tag;
		opd_valid = rdy;
		opd_tag = otag;
		opd_data = data;
		@(negedge clk);
		ok = is_itof ? itof_issue_ready : fsgn_issue_ready;
		@(posedge clk);
		#1;
		itof_issue_valid = 1'b0;
		fsgn_issue_valid = 1'b0;
		opd_valid = 1'b0;
	endtask

	task automatic issue(input logic is_itof, input logic [1:0] op, input tag_t tag,
		input logic [31:0] data, input logic rdy, input tag_t otag);
		logic ok;
		int tries;
		ok = 1'b0;
		tries = 0;
		while (!ok && tries < 50) begin
			try_issue(is_itof, op, tag, data, rdy, otag, ok);
			tries++;
		end
		if (!ok) begin
			$display("Issue of tag %0d was never accepted", tag);
			errors++;
		end
		exp_used[tag] = 1'b1;
		if (rdy) begin
			exp_word[tag] = expect_of(is_itof, op, data);
		end
	endtask

	// Issue ready operands until the station refuses one
	task automatic fill_unit(input logic is_itof, input int base, output int n);
		logic ok;
		logic [1:0] op;
		logic [31:0] d;
		n = 0;
		ok = 1'b1;
		while (ok && n < 8) begin
			op = is_itof ? 2'($urandom_range(1, 0)) : 2'($urandom_range(2, 0));
			d = $urandom();
			try_issue(is_itof, op, tag_t'(base + n), d, 1'b1, '0, ok);
			if (ok) begin
				exp_used[base + n] = 1'b1;
				exp_word[base + n] = expect_of(is_itof, op, d);
				n++;
			end
		end
	endtask

	task automatic gpr_broadcast(input tag_t tag, input logic [31:0] data);
		@(posedge clk);
		#1;
		gpr_cdb_valid = 1'b1;
		gpr_cdb_tag = tag;
		gpr_cdb_data = data;
		@(posedge clk);
		#1;
		gpr_cdb_valid = 1'b0;
	endtask

	task automatic set_cdb_ready(input logic v);
		@(posedge clk);
		#1;
		fpr_cdb_ready = v;
	endtask

	task automatic wait_deliveries(input string name, input int n);
		int cycles;
		cycles = 0;
		while (n_delivered < n && cycles < 200) begin
			@(posedge clk);
			cycles++;
		end
		if (n_delivered < n) begin
			$display("%s: only %0d of %0d results arrived in time", name, n_delivered, n);
			errors++;
		end
		// Room for a stray duplicate to show up
		repeat (5) @(posedge clk);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic signed_conversion();
		logic [31:0] vals [9];
		int e0;
		e0 = errors;
		clear_scoreboard();
		vals[0] = 32'h0000_0000;
		vals[1] = 32'h0000_0001;
		vals[2] = 32'hffff_ffff;
		vals[3] = 32'h7fff_ffff;
		vals[4] = 32'h8000_0000;
		for (int i = 5; i < 9; i++) begin
			// Large magnitudes with low bits set need rounding
			vals[i] = ($urandom() & 32'h3fff_ffff) | 32'h4000_0001;
			if ($urandom_range(1, 0) == 1) begin
				vals[i] = -vals[i];
			end
		end
		for (int i = 0; i < 9; i++) begin
			issue(1'b1, fpu_pkg::OP_ITOF_SIGNED, tag_t'(i), vals[i], 1'b1, '0);
		end
		wait_deliveries("itof_signed", 9);
		verify_scoreboard("itof_signed");
		report_test("itof_signed", e0);
	endtask

	task automatic unsigned_conversion();
		logic [31:0] v;
		int e0;
		e0 = errors;
		clear_scoreboard();
		for (int i = 0; i < 5; i++) begin
			v = (i == 4) ? 32'hffff_ffff : ($urandom() | 32'h8000_0001);
			issue(1'b1, fpu_pkg::OP_ITOF_UNSIGNED, tag_t'(i), v, 1'b1, '0);
		end
		wait_deliveries("itof_unsigned", 5);
		verify_scoreboard("itof_unsigned");
		report_test("itof_unsigned", e0);
	endtask

	task automatic sign_ops();
		logic [31:0] vals [3];
		int e0;
		e0 = errors;
		clear_scoreboard();
		vals[0] = $urandom() | 32'h8000_0000;
		vals[1] = $urandom() & 32'h7fff_ffff;
		vals[2] = $urandom();
		for (int i = 0; i < 3; i++) begin
			for (int op = 0; op < 3; op++) begin
				issue(1'b0, 2'(op), tag_t'(i * 3 + op), vals[i], 1'b1, '0);
			end
		end
		wait_deliveries("sign_ops", 9);
		verify_scoreboard("sign_ops");
		report_test("sign_ops", e0);
	endtask

	task automatic operand_wakeup();
		logic [31:0] d9;
		logic [31:0] d10;
		int e0;
		e0 = errors;
		clear_scoreboard();
		d9 = $urandom();
		d10 = $urandom();
		issue(1'b1, fpu_pkg::OP_ITOF_SIGNED, tag_t'(1), '0, 1'b0, tag_t'(9));
		issue(1'b1, fpu_pkg::OP_ITOF_UNSIGNED, tag_t'(2), '0, 1'b0, tag_t'(10));
		issue(1'b0, fpu_pkg::OP_FSGN_NEG, tag_t'(3), '0, 1'b0, tag_t'(9));
		repeat (10) @(posedge clk);
		check_tag("wakeup results before broadcast", tag_t'(0), tag_t'(n_delivered));
		exp_word[1] = ref_itof(d9, 1'b1);
		exp_word[2] = ref_itof(d10, 1'b0);
		exp_word[3] = ref_fsgn(fpu_pkg::OP_FSGN_NEG, d9);
		gpr_broadcast(tag_t'(9), d9);
		gpr_broadcast(tag_t'(10), d10);
		wait_deliveries("wakeup", 3);
		verify_scoreboard("wakeup");
		report_test("wakeup", e0);
	endtask

	task automatic back_pressure();
		int n_itof;
		int n_fsgn;
		int e0;
		e0 = errors;
		clear_scoreboard();
		set_cdb_ready(1'b0);
		fill_unit(1'b1, 0, n_itof);
		fill_unit(1'b0, 8, n_fsgn);
		@(negedge clk);
		if (itof_issue_ready || fsgn_issue_ready || n_itof == 0 || n_fsgn == 0) begin
			$display("back_pressure: the stations did not fill up with the FPR CDB stalled");
			errors++;
		end
		set_cdb_ready(1'b1);
		wait_deliveries("back_pressure", n_itof + n_fsgn);
		check_tag("back_pressure total", tag_t'(n_itof + n_fsgn), tag_t'(n_delivered));
		verify_scoreboard("back_pressure");
		report_test("back_pressure", e0);
	endtask

	task automatic arbitration();
		int n_itof;
		int n_fsgn;
		int pairs;
		int e0;
		e0 = errors;
		clear_scoreboard();
		set_cdb_ready(1'b0);
		fill_unit(1'b1, 0, n_itof);
		fill_unit(1'b0, 8, n_fsgn);
		set_cdb_ready(1'b1);
		wait_deliveries("arbitration", n_itof + n_fsgn);
		pairs = (n_itof < n_fsgn) ? n_itof : n_fsgn;
		// Tag bit 3 tells the units apart
		for (int i = 1; i < 2 * pairs && i < order_q.size(); i++) begin
			check_tag($sformatf("arbitration unit of delivery %0d", i),
				tag_t'(!order_q[i - 1][3]), tag_t'(order_q[i][3]));
		end
		verify_scoreboard("arbitration");
		report_test("arbitration", e0);
	endtask

	initial begin
		void'($urandom(50));
		reset = 1'b1;
		itof_issue_valid = 1'b0;
		fsgn_issue_valid = 1'b0;
		issue_op = '0;
		issue_tag = '0;
		opd_valid = 1'b0;
		opd_tag = '0;
		opd_data = '0;
		gpr_cdb_valid = 1'b0;
		gpr_cdb_tag = '0;
		gpr_cdb_data = '0;
		fpr_cdb_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		signed_conversion();
		unsigned_conversion();
		sign_ops();
		operand_wakeup();
		back_pressure();
		arbitration();
		$display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(N_TESTS * 2000);
		$display("Watchdog expired after %0d ns, the run is stuck", N_TESTS * 2000);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== fpu_issue_top.sv ====
`timescale 1ns/1ps

module fpu_issue_top (
	input logic clk,
	input logic reset,
	input logic itof_issue_valid,
	input logic fsgn_issue_valid,
	input logic [fpu_pkg::OP_WIDTH-1:0] issue_op,
	input logic [fpu_pkg::ROB_WIDTH-1:0] issue_tag,
	input logic opd_valid,
	input logic [fpu_pkg::ROB_WIDTH-1:0] opd_tag,
	input logic [fpu_pkg::XLEN-1:0] opd_data,
	input logic gpr_cdb_valid,
	input logic [fpu_pkg::ROB_WIDTH-1:0] gpr_cdb_tag,
	input logic [fpu_pkg::XLEN-1:0] gpr_cdb_data,
	input logic fpr_cdb_ready,
	output logic itof_issue_ready,
	output logic fsgn_issue_ready,
	output logic fpr_cdb_valid,
	output logic [fpu_pkg::ROB_WIDTH-1:0] fpr_cdb_tag,
	output fpu_pkg::fp_word_u fpr_cdb_data
);
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Station to unit
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic itof_disp_valid;
	logic itof_disp_ready;
	logic [fpu_pkg::OP_WIDTH-1:0] itof_disp_op;
	logic [fpu_pkg::ROB_WIDTH-1:0] itof_disp_tag;
	logic [fpu_pkg::XLEN-1:0] itof_disp_data;

	logic fsgn_disp_valid;
	logic fsgn_disp_ready;
	logic [fpu_pkg::OP_WIDTH-1:0] fsgn_disp_op;
	logic [fpu_pkg::ROB_WIDTH-1:0] fsgn_disp_tag;
	logic [fpu_pkg::XLEN-1:0] fsgn_disp_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Unit to arbiter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	logic req_itof;
	logic gnt_itof;
	logic [fpu_pkg::ROB_WIDTH-1:0] tag_itof;
	fpu_pkg::fp_word_u data_itof;

	logic req_fsgn;
	logic gnt_fsgn;
	logic [fpu_pkg::ROB_WIDTH-1:0] tag_fsgn;
	fpu_pkg::fp_word_u data_fsgn;

	opd_station u_itof_station (
		.clk(clk),
		.reset(reset),
		.issue_valid(itof_issue_valid),
		.issue_op(issue_op),
		.issue_tag(issue_tag),
		.opd_valid(opd_valid),
		.opd_tag(opd_tag),
		.opd_data(opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.disp_ready(itof_disp_ready),
		.issue_ready(itof_issue_ready),
		.disp_valid(itof_disp_valid),
		.disp_op(itof_disp_op),
		.disp_tag(itof_disp_tag),
		.disp_data(itof_disp_data)
	);

	opd_station u_fsgn_station (
		.clk(clk),
		.reset(reset),
		.issue_valid(fsgn_issue_valid),
		.issue_op(issue_op),
		.issue_tag(issue_tag),
		.opd_valid(opd_valid),
		.opd_tag(opd_tag),
		.opd_data(opd_data),
		.gpr_cdb_valid(gpr_cdb_valid),
		.gpr_cdb_tag(gpr_cdb_tag),
		.gpr_cdb_data(gpr_cdb_data),
		.disp_ready(fsgn_disp_ready),
		.issue_ready(fsgn_issue_ready),
		.disp_valid(fsgn_disp_valid),
		.disp_op(fsgn_disp_op),
		.disp_tag(fsgn_disp_tag),
		.disp_data(fsgn_disp_data)
	);

	itof_convert u_itof_convert (
		.clk(clk),
		.reset(reset),
		.disp_valid(itof_disp_valid),
		.disp_op(itof_disp_op),
		.disp_tag(itof_disp_tag),
		.disp_data(itof_disp_data),
		.gnt(gnt_itof),
		.disp_ready(itof_disp_ready),
		.req(req_itof),
		.req_tag(tag_itof),
		.req_data(data_itof)
	);

	fsgn_unit u_fsgn_unit (
		.clk(clk),
		.reset(reset),
		.disp_valid(fsgn_disp_valid),
		.disp_op(fsgn_disp_op),
		.disp_tag(fsgn_disp_tag),
		.disp_data(fsgn_disp_data),
		.gnt(gnt_fsgn),
		.disp_ready(fsgn_disp_ready),
		.req(req_fsgn),
		.req_tag(tag_fsgn),
		.req_data(data_fsgn)
	);

	fpr_cdb_arbiter u_fpr_cdb_arbiter (
		.clk(clk),
		.reset(reset),
		.req_itof(req_itof),
		.tag_itof(tag_itof),
		.data_itof(data_itof),
		.req_fsgn(req_fsgn),
		.tag_fsgn(tag_fsgn),
		.data_fsgn(data_fsgn),
		.fpr_cdb_ready(fpr_cdb_ready),
		.gnt_itof(gnt_itof),
		.gnt_fsgn(gnt_fsgn),
		.fpr_cdb_valid(fpr_cdb_valid),
		.fpr_cdb_tag(fpr_cdb_tag),
		.fpr_cdb_data(fpr_cdb_data)
	);

endmodule

// ==== fpu_pkg.sv ====
package fpu_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Widths and sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int ROB_WIDTH = 4;
	localparam int XLEN = 32;
	localparam int OP_WIDTH = 2;
	localparam int N_ENTRY = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Op codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Conversion unit
	localparam logic [OP_WIDTH-1:0] OP_ITOF_SIGNED = 2'd0;
	localparam logic [OP_WIDTH-1:0] OP_ITOF_UNSIGNED = 2'd1;

	// Sign unit
	localparam logic [OP_WIDTH-1:0] OP_FSGN_MOVE = 2'd0;
	localparam logic [OP_WIDTH-1:0] OP_FSGN_NEG = 2'd1;
	localparam logic [OP_WIDTH-1:0] OP_FSGN_ABS = 2'd2;

	// Single precision
	localparam int EXP_BIAS = 127;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Float word, raw bits or IEEE fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef union packed {
		logic [XLEN-1:0] raw;
		struct packed {
			logic sign;
			logic [7:0] exp;
			logic [22:0] frac;
		} fields;
	} fp_word_u;

endpackage

// ==== fsgn_unit.sv ====
`timescale 1ns/1ps

module fsgn_unit (
	input logic clk,
	input logic reset,
	input logic disp_valid,
	input logic [fpu_pkg::OP_WIDTH-1:0] disp_op,
	input logic [fpu_pkg::ROB_WIDTH-1:0] disp_tag,
	input fpu_pkg::fp_word_u disp_data,
	input logic gnt,
	output logic disp_ready,
	output logic req,
	output logic [fpu_pkg::ROB_WIDTH-1:0] req_tag,
	output fpu_pkg::fp_word_u req_data
);
	logic disp_fire;
	fpu_pkg::fp_word_u res;

	// Slot takes a new op when empty or leaving this cycle
	assign disp_ready = !req || gnt;
	assign disp_fire = disp_valid && disp_ready;

	always_comb begin
		res = disp_data;
		case (disp_op)
			fpu_pkg::OP_FSGN_NEG: res.fields.sign = ~disp_data.fields.sign;
			fpu_pkg::OP_FSGN_ABS: res.fields.sign = 1'b0;
			default: res = disp_data;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			req <= 1'b0;
		end else if (disp_ready) begin
			req <= disp_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_fire) begin
			req_tag <= disp_tag;
			req_data <= res;
		end
	end

endmodule

// ==== itof_convert.sv ====
`timescale 1ns/1ps

module itof_convert (
	input logic clk,
	input logic reset,
	input logic disp_valid,
	input logic [fpu_pkg::OP_WIDTH-1:0] disp_op,
	input logic [fpu_pkg::ROB_WIDTH-1:0] disp_tag,
	input logic [fpu_pkg::XLEN-1:0] disp_data,
	input logic gnt,
	output logic disp_ready,
	output logic req,
	output logic [fpu_pkg::ROB_WIDTH-1:0] req_tag,
	output fpu_pkg::fp_word_u req_data
);
	logic s1_valid;
	logic [fpu_pkg::ROB_WIDTH-1:0] s1_tag;
	logic s1_sign;
	logic [fpu_pkg::XLEN-1:0] s1_mag;
	logic [$clog2(fpu_pkg::XLEN):0] s1_lzc;

	logic in_sign;
	logic [fpu_pkg::XLEN-1:0] in_mag;
	logic slot_free;
	logic s1_free;
	logic s1_move;
	logic disp_fire;

	logic [fpu_pkg::XLEN-1:0] norm;
	logic round_up;
	logic [23:0] rounded;
	fpu_pkg::fp_word_u res;

	function automatic logic [$clog2(fpu_pkg::XLEN):0] count_lz(input logic [fpu_pkg::XLEN-1:0] v);
		logic [$clog2(fpu_pkg::XLEN):0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = fpu_pkg::XLEN - 1; i >= 0; i--) begin
			if (!found && !v[i]) begin
				n = n + 1'b1;
			end else begin
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// Stage advance, a stage moves only into a free or draining slot
	assign slot_free = !req || gnt;
	assign s1_move = s1_valid && slot_free;
	assign s1_free = !s1_valid || slot_free;
	assign disp_ready = s1_free;
	assign disp_fire = disp_valid && disp_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1: magnitude
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign in_sign = disp_op == fpu_pkg::OP_ITOF_SIGNED && disp_data[fpu_pkg::XLEN-1];
	assign in_mag = in_sign ? -disp_data : disp_data;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2: normalize and round
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign norm = s1_mag << s1_lzc;
	// Guard bit 7, sticky below it, lsb bit 8
	assign round_up = norm[7] && ((|norm[6:0]) || norm[8]);
	assign rounded = {1'b0, norm[30:8]} + 24'(round_up);

	always_comb begin
		res.fields.sign = s1_sign;
		res.fields.exp = 8'(fpu_pkg::EXP_BIAS + fpu_pkg::XLEN - 1 - int'(s1_lzc))
			+ 8'(rounded[23]);
		res.fields.frac = rounded[22:0];
		if (s1_mag == '0) begin
			res.raw = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			req <= 1'b0;
		end else begin
			if (s1_free) s1_valid <= disp_fire;
			if (slot_free) req <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (disp_fire) begin
			s1_tag <= disp_tag;
			s1_sign <= in_sign;
			s1_mag <= in_mag;
			s1_lzc <= count_lz(in_mag);
		end
		if (s1_move) begin
			req_tag <= s1_tag;
			req_data <= res;
		end
	end

endmodule

// ==== opd_station.sv ====
`timescale 1ns/1ps

module opd_station (
	input logic clk,
	input logic reset,
	input logic issue_valid,
	input logic [fpu_pkg::OP_WIDTH-1:0] issue_op,
	input logic [fpu_pkg::ROB_WIDTH-1:0] issue_tag,
	input logic opd_valid,
	input logic [fpu_pkg::ROB_WIDTH-1:0] opd_tag,
	input logic [fpu_pkg::XLEN-1:0] opd_data,
	input logic gpr_cdb_valid,
	input logic [fpu_pkg::ROB_WIDTH-1:0] gpr_cdb_tag,
	input logic [fpu_pkg::XLEN-1:0] gpr_cdb_data,
	input logic disp_ready,
	output logic issue_ready,
	output logic disp_valid,
	output logic [fpu_pkg::OP_WIDTH-1:0] disp_op,
	output logic [fpu_pkg::ROB_WIDTH-1:0] disp_tag,
	output logic [fpu_pkg::XLEN-1:0] disp_data
);
	// Entries, index 0 is the oldest
	logic [fpu_pkg::N_ENTRY-1:0] e_valid;
	logic [fpu_pkg::N_ENTRY-1:0] e_rdy;
	logic [fpu_pkg::OP_WIDTH-1:0] e_op [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::ROB_WIDTH-1:0] e_tag [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::ROB_WIDTH-1:0] e_otag [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::XLEN-1:0] e_odata [fpu_pkg::N_ENTRY];

	// Operands after this cycle's wakeup
	logic [fpu_pkg::N_ENTRY-1:0] w_rdy;
	logic [fpu_pkg::XLEN-1:0] w_odata [fpu_pkg::N_ENTRY];
	logic new_rdy;
	logic [fpu_pkg::XLEN-1:0] new_odata;

	logic [fpu_pkg::N_ENTRY-1:0] n_valid;
	logic [fpu_pkg::N_ENTRY-1:0] n_rdy;
	logic [fpu_pkg::OP_WIDTH-1:0] n_op [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::ROB_WIDTH-1:0] n_tag [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::ROB_WIDTH-1:0] n_otag [fpu_pkg::N_ENTRY];
	logic [fpu_pkg::XLEN-1:0] n_odata [fpu_pkg::N_ENTRY];

	logic [$clog2(fpu_pkg::N_ENTRY)-1:0] disp_sel;
	logic disp_fire;
	logic issue_fire;

	// GPR CDB wakeup
	always_comb begin
		for (int i = 0; i < fpu_pkg::N_ENTRY; i++) begin
			w_rdy[i] = e_rdy[i];
			w_odata[i] = e_odata[i];
			if (!e_rdy[i] && gpr_cdb_valid && gpr_cdb_tag == e_otag[i]) begin
				w_rdy[i] = 1'b1;
				w_odata[i] = gpr_cdb_data;
			end
		end
	end

	// Operand may arrive on the CDB in the issue cycle itself
	assign new_rdy = opd_valid || (gpr_cdb_valid && gpr_cdb_tag == opd_tag);
	assign new_odata = opd_valid ? opd_data : gpr_cdb_data;

	// Oldest ready entry wins
	always_comb begin
		disp_valid = 1'b0;
		disp_sel = '0;
		for (int i = fpu_pkg::N_ENTRY - 1; i >= 0; i--) begin
			if (e_valid[i] && e_rdy[i]) begin
				disp_valid = 1'b1;
				disp_sel = ($clog2(fpu_pkg::N_ENTRY))'(i);
			end
		end
	end

	assign disp_op = e_op[disp_sel];
	assign disp_tag = e_tag[disp_sel];
	assign disp_data = e_odata[disp_sel];
	assign disp_fire = disp_valid && disp_ready;
	assign issue_ready = !e_valid[fpu_pkg::N_ENTRY-1] || disp_fire;
	assign issue_fire = issue_valid && issue_ready;

	// Close the gap left by dispatch, then append at the first free slot
	always_comb begin : next_state
		int src;
		logic placed;
		placed = 1'b0;
		for (int i = 0; i < fpu_pkg::N_ENTRY; i++) begin
			src = i;
			if (disp_fire && i >= int'(disp_sel) && i < fpu_pkg::N_ENTRY - 1) begin
				src = i + 1;
			end
			n_valid[i] = e_valid[src];
			if (disp_fire && i >= int'(disp_sel) && i == fpu_pkg::N_ENTRY - 1) begin
				n_valid[i] = 1'b0;
			end
			n_rdy[i] = w_rdy[src];
			n_op[i] = e_op[src];
			n_tag[i] = e_tag[src];
			n_otag[i] = e_otag[src];
			n_odata[i] = w_odata[src];
		end
		for (int i = 0; i < fpu_pkg::N_ENTRY; i++) begin
			if (issue_fire && !placed && !n_valid[i]) begin
				n_valid[i] = 1'b1;
				n_rdy[i] = new_rdy;
				n_op[i] = issue_op;
				n_tag[i] = issue_tag;
				n_otag[i] = opd_tag;
				n_odata[i] = new_odata;
				placed = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			e_valid <= '0;
		end else begin
			e_valid <= n_valid;
		end
	end

	always_ff @(posedge clk) begin
		e_rdy <= n_rdy;
		e_op <= n_op;
		e_tag <= n_tag;
		e_otag <= n_otag;
		e_odata <= n_odata;
	end

endmodule
